// File: mips_pkg.sv
package mips_pkg;

	////////////////////////////////////////
	// widths
	////////////////////////////////////////

	// data path and address width
	localparam int xlen = 32;
	// register file address width
	localparam int reg_addr_w = 5;

	////////////////////////////////////////
	// opcodes and funct codes
	////////////////////////////////////////

	localparam logic [5:0] op_rtype = 6'b000000;
	localparam logic [5:0] op_lw    = 6'b100011;
	localparam logic [5:0] op_sw    = 6'b101011;

	// only the low four bits are compared in the alu control
	localparam logic [5:0] funct_add = 6'b100000;
	localparam logic [5:0] funct_sub = 6'b100010;
	localparam logic [5:0] funct_and = 6'b100100;
	localparam logic [5:0] funct_or  = 6'b100101;
	localparam logic [5:0] funct_slt = 6'b101010;
	localparam logic [5:0] funct_nor = 6'b100111;

	////////////////////////////////////////
	// alu operations and forwarding selects
	////////////////////////////////////////

	localparam logic [3:0] alu_and = 4'b0000;
	localparam logic [3:0] alu_or  = 4'b0001;
	localparam logic [3:0] alu_add = 4'b0010;
	localparam logic [3:0] alu_sub = 4'b0110;
	localparam logic [3:0] alu_slt = 4'b0111;
	localparam logic [3:0] alu_nor = 4'b1100;

	// operand from id/ex, from ex/mem result, from write-back
	localparam logic [1:0] fwd_reg = 2'b00;
	localparam logic [1:0] fwd_mem = 2'b01;
	localparam logic [1:0] fwd_wb  = 2'b10;

	////////////////////////////////////////
	// instruction word
	////////////////////////////////////////

	// same 32 bits seen as R format or as I format (lw/sw)
	typedef union packed {
		struct packed {
			logic [5:0] op;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [4:0] rd;
			logic [4:0] shamt;
			logic [5:0] funct;
		} r;
		struct packed {
			logic [5:0] op;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [15:0] imm;
		} i;
	} instr_t;

endpackage

// File: reg_file.sv
`timescale 1ns/1ps

module reg_file import mips_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic [reg_addr_w-1:0] ra1,
	input  logic [reg_addr_w-1:0] ra2,
	input  logic [reg_addr_w-1:0] wa,
	input  logic                  we,
	input  logic [xlen-1:0]       wd,
	output logic [xlen-1:0]       rd1,
	output logic [xlen-1:0]       rd2
);

	// register 0 has no storage
	logic [xlen-1:0] regs [1:31];

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int k = 1; k < 32; k++) begin
				regs[k] <= '0;
			end
		end else if (we && wa != '0) begin
			regs[wa] <= wd;
		end
	end

	// write-back in the same cycle wins over the stored value
	assign rd1 = (ra1 == '0) ? '0 : (we && wa == ra1) ? wd : regs[ra1];
	assign rd2 = (ra2 == '0) ? '0 : (we && wa == ra2) ? wd : regs[ra2];

endmodule

// File: instr_decode.sv
`timescale 1ns/1ps

module instr_decode import mips_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic [xlen-1:0]       instr,
	input  logic                  wb_en,
	input  logic [reg_addr_w-1:0] wb_addr,
	input  logic [xlen-1:0]       wb_data,
	output logic [xlen-1:0]       pc,
	output logic [reg_addr_w-1:0] ex_rs,
	output logic [reg_addr_w-1:0] ex_rt,
	output logic [reg_addr_w-1:0] ex_rd,
	output logic [xlen-1:0]       ex_rd1,
	output logic [xlen-1:0]       ex_rd2,
	output logic [xlen-1:0]       ex_imm,
	output logic                  ex_reg_dst,
	output logic                  ex_alu_src,
	output logic [1:0]            ex_alu_op,
	output logic                  ex_mem_read,
	output logic                  ex_mem_write,
	output logic                  ex_reg_write,
	output logic                  ex_mem_to_reg
);

	instr_t id_instr;
	logic id_valid;
	logic stall;
	logic bubble;
	logic [xlen-1:0] rd1;
	logic [xlen-1:0] rd2;
	// decoded control levels
	logic reg_dst, alu_src, mem_read, mem_write, reg_write, mem_to_reg;
	logic [1:0] alu_op;

	////////////////////////////////////////
	// pc and if/id
	////////////////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pc <= '0;
			id_valid <= 1'b0;
		end else if (!stall) begin
			pc <= pc + xlen'(4);
			id_valid <= 1'b1;
		end
	end

	// instruction word held during a stall
	always_ff @(posedge clk) begin
		if (!stall) begin
			id_instr <= instr;
		end
	end

	////////////////////////////////////////
	// control decode
	////////////////////////////////////////

	always_comb begin
		// unknown opcode falls through as a no-op
		reg_dst = 1'b0;
		alu_src = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		reg_write = 1'b0;
		mem_to_reg = 1'b0;
		alu_op = 2'b00;
		case (id_instr.i.op)
			op_rtype: begin
				// result to rd, alu op from funct
				reg_dst = 1'b1;
				reg_write = 1'b1;
				alu_op = 2'b10;
			end
			op_lw: begin
				// base plus offset, memory data to rt
				alu_src = 1'b1;
				mem_read = 1'b1;
				reg_write = 1'b1;
				mem_to_reg = 1'b1;
			end
			op_sw: begin
				alu_src = 1'b1;
				mem_write = 1'b1;
			end
			default: ;
		endcase
	end

	// load in ex feeding the instruction in id
	assign stall = id_valid && ex_mem_read &&
		(ex_rt == id_instr.r.rs || ex_rt == id_instr.r.rt);
	assign bubble = stall || !id_valid;

	reg_file u_regs (
		.clk(clk), .rst(rst),
		.ra1(id_instr.r.rs), .ra2(id_instr.r.rt),
		.wa(wb_addr), .we(wb_en), .wd(wb_data),
		.rd1(rd1), .rd2(rd2)
	);

	////////////////////////////////////////
	// id/ex
	////////////////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			{ex_reg_dst, ex_alu_src, ex_mem_read, ex_mem_write} <= '0;
			{ex_reg_write, ex_mem_to_reg} <= '0;
			ex_alu_op <= 2'b00;
		end else begin
			// strobes low on a bubble
			ex_reg_dst <= reg_dst;
			ex_alu_src <= alu_src;
			ex_alu_op <= alu_op;
			ex_mem_read <= mem_read && !bubble;
			ex_mem_write <= mem_write && !bubble;
			ex_reg_write <= reg_write && !bubble;
			ex_mem_to_reg <= mem_to_reg;
		end
	end

	always_ff @(posedge clk) begin
		ex_rs <= id_instr.r.rs;
		ex_rt <= id_instr.r.rt;
		ex_rd <= id_instr.r.rd;
		ex_rd1 <= rd1;
		ex_rd2 <= rd2;
		// sign extension, low six bits still hold funct
		ex_imm <= {{(xlen-16){id_instr.i.imm[15]}}, id_instr.i.imm};
	end

endmodule

// File: exec_stage.sv
`timescale 1ns/1ps

module exec_stage import mips_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic [reg_addr_w-1:0] ex_rs,
	input  logic [reg_addr_w-1:0] ex_rt,
	input  logic [reg_addr_w-1:0] ex_rd,
	input  logic [xlen-1:0]       ex_rd1,
	input  logic [xlen-1:0]       ex_rd2,
	input  logic [xlen-1:0]       ex_imm,
	input  logic                  ex_reg_dst,
	input  logic                  ex_alu_src,
	input  logic [1:0]            ex_alu_op,
	input  logic                  ex_mem_read,
	input  logic                  ex_mem_write,
	input  logic                  ex_reg_write,
	input  logic                  ex_mem_to_reg,
	input  logic                  wb_en,
	input  logic [reg_addr_w-1:0] wb_addr,
	input  logic [xlen-1:0]       wb_data,
	output logic [xlen-1:0]       mem_alu_result,
	output logic [xlen-1:0]       mem_store_data,
	output logic [reg_addr_w-1:0] mem_dest,
	output logic                  mem_reg_write,
	output logic                  mem_mem_read,
	output logic                  mem_mem_write,
	output logic                  mem_mem_to_reg
);

	instr_t imm_view;
	logic [1:0] sel_a, sel_b;
	logic [xlen-1:0] opnd_a, opnd_b, fwd_b, alu_res;
	logic [3:0] alu_ctrl;

	// mem stage first, then write-back; register 0 never forwarded
	function automatic logic [1:0] fwd_select(input logic [reg_addr_w-1:0] src,
		input logic mem_we, input logic [reg_addr_w-1:0] mem_a,
		input logic wb_we, input logic [reg_addr_w-1:0] wb_a);
		logic [1:0] sel;
		sel = fwd_reg;
		if (mem_we && mem_a != '0 && mem_a == src)
			sel = fwd_mem;
		else if (wb_we && wb_a != '0 && wb_a == src)
			sel = fwd_wb;
		return sel;
	endfunction

	////////////////////////////////////////
	// operand select
	////////////////////////////////////////

	assign sel_a = fwd_select(ex_rs, mem_reg_write, mem_dest, wb_en, wb_addr);
	assign sel_b = fwd_select(ex_rt, mem_reg_write, mem_dest, wb_en, wb_addr);

	assign opnd_a = (sel_a == fwd_mem) ? mem_alu_result :
		(sel_a == fwd_wb) ? wb_data : ex_rd1;
	// also the store data
	assign fwd_b = (sel_b == fwd_mem) ? mem_alu_result :
		(sel_b == fwd_wb) ? wb_data : ex_rd2;
	assign opnd_b = ex_alu_src ? ex_imm : fwd_b;

	////////////////////////////////////////
	// alu control and alu
	////////////////////////////////////////

	// immediate low half is the instruction low half, so funct sits in r view
	assign imm_view = ex_imm;

	always_comb begin
		alu_ctrl = alu_add;
		if (ex_alu_op[1]) begin
			case (imm_view.r.funct[3:0])
				funct_add[3:0]: alu_ctrl = alu_add;
				funct_sub[3:0]: alu_ctrl = alu_sub;
				funct_and[3:0]: alu_ctrl = alu_and;
				funct_or[3:0]:  alu_ctrl = alu_or;
				funct_slt[3:0]: alu_ctrl = alu_slt;
				funct_nor[3:0]: alu_ctrl = alu_nor;
				// alu gives zero for an unknown funct
				default:        alu_ctrl = 4'b1111;
			endcase
		end
	end

	always_comb begin
		case (alu_ctrl)
			alu_and: alu_res = opnd_a & opnd_b;
			alu_or:  alu_res = opnd_a | opnd_b;
			alu_add: alu_res = opnd_a + opnd_b;
			alu_sub: alu_res = opnd_a - opnd_b;
			alu_slt: alu_res = xlen'($signed(opnd_a) < $signed(opnd_b));
			alu_nor: alu_res = ~(opnd_a | opnd_b);
			default: alu_res = '0;
		endcase
	end

	////////////////////////////////////////
	// ex/mem
	////////////////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			{mem_reg_write, mem_mem_read, mem_mem_write, mem_mem_to_reg} <= '0;
		end else begin
			mem_reg_write <= ex_reg_write;
			mem_mem_read <= ex_mem_read;
			mem_mem_write <= ex_mem_write;
			mem_mem_to_reg <= ex_mem_to_reg;
		end
	end

	always_ff @(posedge clk) begin
		mem_alu_result <= alu_res;
		mem_store_data <= fwd_b;
		// rd for R type, rt for loads
		mem_dest <= ex_reg_dst ? ex_rd : ex_rt;
	end

endmodule

// File: mem_writeback.sv
`timescale 1ns/1ps

module mem_writeback import mips_pkg::*; #(
	parameter int dmem_depth = 64
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic [xlen-1:0]       mem_alu_result,
	input  logic [xlen-1:0]       mem_store_data,
	input  logic [reg_addr_w-1:0] mem_dest,
	input  logic                  mem_reg_write,
	input  logic                  mem_mem_read,
	input  logic                  mem_mem_write,
	input  logic                  mem_mem_to_reg,
	output logic                  wb_en,
	output logic [reg_addr_w-1:0] wb_addr,
	output logic [xlen-1:0]       wb_data
);

	localparam int aw = $clog2(dmem_depth);

	logic [xlen-1:0] dmem [dmem_depth];
	logic [aw-1:0] word_idx;
	logic [xlen-1:0] load_data;
	logic [xlen-1:0] wb_load, wb_alu;
	logic wb_mem_to_reg;

	////////////////////////////////////////
	// data memory
	////////////////////////////////////////

	// word address, wraps at the memory depth
	assign word_idx = mem_alu_result[aw+1:2];

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int k = 0; k < dmem_depth; k++) begin
				dmem[k] <= '0;
			end
		end else if (mem_mem_write) begin
			dmem[word_idx] <= mem_store_data;
		end
	end

	// asynchronous read in the mem stage
	assign load_data = mem_mem_read ? dmem[word_idx] : '0;

	////////////////////////////////////////
	// mem/wb and write-back select
	////////////////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wb_en <= 1'b0;
			wb_mem_to_reg <= 1'b0;
		end else begin
			wb_en <= mem_reg_write;
			wb_mem_to_reg <= mem_mem_to_reg;
		end
	end

	always_ff @(posedge clk) begin
		wb_addr <= mem_dest;
		wb_load <= load_data;
		wb_alu <= mem_alu_result;
	end

	assign wb_data = wb_mem_to_reg ? wb_load : wb_alu;

endmodule

// File: mips_core.sv
`timescale 1ns/1ps

module mips_core import mips_pkg::*; #(
	parameter int dmem_depth = 64
) (
	input  logic                  clk,
	input  logic                  rst,
	output logic [xlen-1:0]       pc,
	input  logic [xlen-1:0]       instr,
	output logic                  wb_en,
	output logic [reg_addr_w-1:0] wb_addr,
	output logic [xlen-1:0]       wb_data
);

	// id/ex register outputs
	logic [reg_addr_w-1:0] ex_rs;
	logic [reg_addr_w-1:0] ex_rt;
	logic [reg_addr_w-1:0] ex_rd;
	logic [xlen-1:0]       ex_rd1;
	logic [xlen-1:0]       ex_rd2;
	logic [xlen-1:0]       ex_imm;
	logic                  ex_reg_dst;
	logic                  ex_alu_src;
	logic [1:0]            ex_alu_op;
	logic                  ex_mem_read;
	logic                  ex_mem_write;
	logic                  ex_reg_write;
	logic                  ex_mem_to_reg;

	// ex/mem register outputs
	logic [xlen-1:0]       mem_alu_result;
	logic [xlen-1:0]       mem_store_data;
	logic [reg_addr_w-1:0] mem_dest;
	logic                  mem_reg_write;
	logic                  mem_mem_read;
	logic                  mem_mem_write;
	logic                  mem_mem_to_reg;

	// fetch, decode, hazard stall, register file
	instr_decode u_decode (
		.clk(clk), .rst(rst), .instr(instr),
		.wb_en(wb_en), .wb_addr(wb_addr), .wb_data(wb_data),
		.pc(pc), .ex_rs(ex_rs), .ex_rt(ex_rt), .ex_rd(ex_rd),
		.ex_rd1(ex_rd1), .ex_rd2(ex_rd2), .ex_imm(ex_imm),
		.ex_reg_dst(ex_reg_dst), .ex_alu_src(ex_alu_src), .ex_alu_op(ex_alu_op),
		.ex_mem_read(ex_mem_read), .ex_mem_write(ex_mem_write),
		.ex_reg_write(ex_reg_write), .ex_mem_to_reg(ex_mem_to_reg)
	);

	// forwarding and alu
	exec_stage u_exec (
		.clk(clk), .rst(rst),
		.ex_rs(ex_rs), .ex_rt(ex_rt), .ex_rd(ex_rd),
		.ex_rd1(ex_rd1), .ex_rd2(ex_rd2), .ex_imm(ex_imm),
		.ex_reg_dst(ex_reg_dst), .ex_alu_src(ex_alu_src), .ex_alu_op(ex_alu_op),
		.ex_mem_read(ex_mem_read), .ex_mem_write(ex_mem_write),
		.ex_reg_write(ex_reg_write), .ex_mem_to_reg(ex_mem_to_reg),
		.wb_en(wb_en), .wb_addr(wb_addr), .wb_data(wb_data),
		.mem_alu_result(mem_alu_result), .mem_store_data(mem_store_data),
		.mem_dest(mem_dest), .mem_reg_write(mem_reg_write),
		.mem_mem_read(mem_mem_read), .mem_mem_write(mem_mem_write),
		.mem_mem_to_reg(mem_mem_to_reg)
	);

	// data memory and write-back select
	mem_writeback #(.dmem_depth(dmem_depth)) u_mem_wb (
		.clk(clk), .rst(rst),
		.mem_alu_result(mem_alu_result), .mem_store_data(mem_store_data),
		.mem_dest(mem_dest), .mem_reg_write(mem_reg_write),
		.mem_mem_read(mem_mem_read), .mem_mem_write(mem_mem_write),
		.mem_mem_to_reg(mem_mem_to_reg),
		.wb_en(wb_en), .wb_addr(wb_addr), .wb_data(wb_data)
	);

endmodule

// File: tb_mips_core.sv
`timescale 1ns/1ps

module tb_mips_core import mips_pkg::*; ();

	localparam int rom_depth = 256;
	localparam int dmem_words = 64;
	localparam int n_tests = 5;
	// every test gets the longest program plus slack, at 100 ns per cycle
	localparam int watchdog_ns = n_tests * (rom_depth + 10) * 100;
	// opcode 6'h3f is not decoded, so this word writes nothing
	localparam logic [31:0] nop_word = 32'hfc00_0000;

	logic clk = 1'b0;
	logic rst;
	logic [xlen-1:0] pc;
	logic [xlen-1:0] instr;
	logic wb_en;
	logic [reg_addr_w-1:0] wb_addr;
	logic [xlen-1:0] wb_data;

	logic [31:0] rom [rom_depth];
	logic [31:0] prog [$];
	logic [4:0] exp_addr [$];
	logic [31:0] exp_data [$];
	int exp_stalls;
	logic [31:0] rand_state = 32'hc00b;
	int errors = 0;
	int tests_failed = 0;

	mips_core #(.dmem_depth(dmem_words)) u_dut (
		.clk(clk), .rst(rst), .pc(pc), .instr(instr),
		.wb_en(wb_en), .wb_addr(wb_addr), .wb_data(wb_data)
	);

	always #50 clk = ~clk;

	// program rom read combinationally at the word address
	assign instr = (pc[31:2] < rom_depth) ? rom[pc[31:2]] : nop_word;

	////////////////////////////////////////
	// stimulus helpers
	////////////////////////////////////////

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	function automatic logic [31:0] next_rand();
		rand_state = xorshift(rand_state);
		return rand_state;
	endfunction

	function automatic logic [31:0] r_word(input logic [5:0] funct, input logic [4:0] rd,
		input logic [4:0] rs, input logic [4:0] rt);
		instr_t w;
		w.r.op = op_rtype;
		w.r.rs = rs;
		w.r.rt = rt;
		w.r.rd = rd;
		w.r.shamt = '0;
		w.r.funct = funct;
		return w;
	endfunction

	function automatic logic [31:0] i_word(input logic [5:0] op, input logic [4:0] rt,
		input logic [4:0] rs, input logic [15:0] imm);
		instr_t w;
		w.i.op = op;
		w.i.rs = rs;
		w.i.rt = rt;
		w.i.imm = imm;
		return w;
	endfunction

	// r31 = -1 from nor of zeros, r30 = 1 from 0 - (-1)
	task automatic setup_regs();
		prog.delete();
		prog.push_back(r_word(funct_nor, 31, 0, 0));
		prog.push_back(r_word(funct_sub, 30, 0, 31));
	endtask

	// shift-and-add chain that doubles rd and adds r30 for every set bit
	task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
		bit started;
		started = 1'b0;
		prog.push_back(r_word(funct_add, rd, 0, 0));
		for (int b = 31; b >= 0; b--) begin
			if (started)
				prog.push_back(r_word(funct_add, rd, rd, rd));
			if (value[b]) begin
				prog.push_back(r_word(funct_add, rd, rd, 30));
				started = 1'b1;
			end
		end
	endtask

	////////////////////////////////////////
	// sequential reference model
	////////////////////////////////////////

	task automatic model_program();
		logic [31:0] mregs [32];
		logic [31:0] mmem [dmem_words];
		instr_t w;
		instr_t nxt;
		logic [31:0] a, b, res, addr;
		exp_addr.delete();
		exp_data.delete();
		exp_stalls = 0;
		foreach (mregs[k])
			mregs[k] = '0;
		foreach (mmem[k])
			mmem[k] = '0;
		for (int n = 0; n < prog.size(); n++) begin
			w = prog[n];
			nxt = (n + 1 < prog.size()) ? prog[n + 1] : nop_word;
			a = mregs[w.r.rs];
			b = mregs[w.r.rt];
			addr = a + {{16{w.i.imm[15]}}, w.i.imm};
			case (w.r.op)
				op_rtype: begin
					case (w.r.funct)
						funct_add: res = a + b;
						funct_sub: res = a - b;
						funct_and: res = a & b;
						funct_or:  res = a | b;
						funct_slt: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						funct_nor: res = ~(a | b);
						default:   res = '0;
					endcase
					exp_addr.push_back(w.r.rd);
					exp_data.push_back(res);
					if (w.r.rd != 0)
						mregs[w.r.rd] = res;
				end
				op_lw: begin
					res = mmem[(addr >> 2) % dmem_words];
					exp_addr.push_back(w.i.rt);
					exp_data.push_back(res);
					if (w.i.rt != 0)
						mregs[w.i.rt] = res;
					// next word names the load target in its rs or rt field
					if (w.i.rt == nxt.r.rs || w.i.rt == nxt.r.rt)
						exp_stalls++;
				end
				op_sw: mmem[(addr >> 2) % dmem_words] = b;
				default: ;
			endcase
		end
	endtask

	////////////////////////////////////////
	// reset and run
	////////////////////////////////////////

	task automatic reset_dut();
		@(posedge clk);
		rst <= 1'b1;
		// two cycles in reset plus the first cycle after it
		for (int c = 0; c < 3; c++) begin
			if (c == 2)
				rst <= 1'b0;
			@(negedge clk);
			assert (pc == 0) else begin
				$display("Mismatch at %0t ns: pc expected 0 actual %h", $time, pc);
				errors++;
			end
			assert (wb_en == 1'b0) else begin
				$display("Mismatch at %0t ns: wb_en expected 0 actual %b", $time, wb_en);
				errors++;
			end
			if (c < 2)
				@(posedge clk);
		end
	endtask

	task automatic run_program(input string name);
		int got, cycles, repeats, limit, errs_before;
		logic [31:0] prev_pc;
		errs_before = errors;
		for (int k = 0; k < rom_depth; k++)
			rom[k] = (k < prog.size()) ? prog[k] : nop_word;
		model_program();
		reset_dut();
		got = 0;
		cycles = 0;
		repeats = 0;
		prev_pc = '0;
		limit = prog.size() + 10;
		while (got < exp_addr.size() && cycles < limit) begin
			@(negedge clk);
			cycles++;
			// pc either holds for a stall or steps by four
			if (pc == prev_pc)
				repeats++;
			else assert (pc == prev_pc + 4) else begin
				$display("Mismatch at %0t ns: pc expected %h actual %h",
					$time, prev_pc + 4, pc);
				errors++;
			end
			prev_pc = pc;
			if (wb_en) begin
				assert (wb_addr == exp_addr[got]) else begin
					$display("Mismatch at %0t ns: wb_addr expected %0d actual %0d",
						$time, exp_addr[got], wb_addr);
					errors++;
				end
				assert (wb_data == exp_data[got]) else begin
					$display("Mismatch at %0t ns: wb_data expected %h actual %h",
						$time, exp_data[got], wb_data);
					errors++;
				end
				got++;
			end
		end
		assert (got == exp_addr.size()) else begin
			$display("write-back missing in test %s, saw %0d of %0d",
				name, got, exp_addr.size());
			errors++;
		end
		assert (repeats == exp_stalls) else begin
			$display("Mismatch at %0t ns: pc repeat count expected %0d actual %0d",
				$time, exp_stalls, repeats);
			errors++;
		end
		if (errors != errs_before)
			tests_failed++;
		$display("test %s: %s, %0d write-backs, %0d stalls, %0d errors", name,
			(errors == errs_before) ? "ok" : "failed", got, repeats, errors - errs_before);
	endtask

	////////////////////////////////////////
	// directed tests
	////////////////////////////////////////

	// without loads pc steps by four every cycle
	task automatic reset_and_fetch();
		setup_regs();
		load_const(1, next_rand());
		prog.push_back(r_word(funct_add, 2, 1, 30));
		prog.push_back(r_word(funct_or, 3, 2, 1));
		run_program("reset_and_fetch");
	endtask

	task automatic alu_forwarding();
		logic [31:0] a, b;
		// a negative and b positive, so signed and unsigned slt disagree
		a = next_rand() | 32'h8000_0000;
		b = next_rand() & 32'h7fff_ffff;
		setup_regs();
		load_const(3, a);
		prog.push_back(i_word(op_sw, 3, 0, 16'd0));
		load_const(3, b);
		prog.push_back(i_word(op_sw, 3, 0, 16'd4));
		prog.push_back(i_word(op_lw, 1, 0, 16'd0));
		prog.push_back(i_word(op_lw, 2, 0, 16'd4));
		// spacer keeps the loads free of a stall
		prog.push_back(r_word(funct_or, 12, 31, 30));
		prog.push_back(r_word(funct_add, 4, 1, 2));
		prog.push_back(r_word(funct_sub, 5, 4, 1));
		prog.push_back(r_word(funct_and, 6, 5, 4));
		prog.push_back(r_word(funct_or, 7, 6, 5));
		prog.push_back(r_word(funct_slt, 8, 7, 6));
		prog.push_back(r_word(funct_nor, 9, 8, 7));
		prog.push_back(r_word(funct_slt, 10, 1, 2));
		prog.push_back(r_word(funct_slt, 11, 2, 1));
		run_program("alu_forwarding");
	endtask

	task automatic store_and_load();
		setup_regs();
		load_const(3, next_rand());
		load_const(4, next_rand());
		load_const(5, 32'd100);
		// byte 260 is word 65, which wraps to word 1
		prog.push_back(i_word(op_sw, 3, 0, 16'd260));
		prog.push_back(i_word(op_sw, 4, 5, -16'sd12));
		prog.push_back(i_word(op_sw, 3, 0, 16'd8));
		prog.push_back(i_word(op_lw, 6, 0, 16'd4));
		prog.push_back(i_word(op_lw, 7, 0, 16'd88));
		prog.push_back(i_word(op_lw, 8, 5, -16'sd12));
		prog.push_back(i_word(op_lw, 9, 0, 16'd8));
		run_program("store_and_load");
	endtask

	task automatic load_use_stall();
		setup_regs();
		load_const(3, next_rand());
		prog.push_back(i_word(op_sw, 3, 0, 16'd16));
		prog.push_back(i_word(op_lw, 4, 0, 16'd16));
		prog.push_back(r_word(funct_add, 5, 4, 30));
		prog.push_back(r_word(funct_sub, 6, 5, 4));
		run_program("load_use_stall");
	endtask

	task automatic zero_register();
		setup_regs();
		load_const(3, next_rand());
		// writes to r0 pulse wb_en but must never be read back
		prog.push_back(r_word(funct_add, 0, 3, 30));
		prog.push_back(r_word(funct_add, 7, 0, 3));
		prog.push_back(r_word(funct_or, 8, 0, 0));
		prog.push_back(i_word(op_sw, 3, 0, 16'd20));
		prog.push_back(i_word(op_lw, 0, 0, 16'd20));
		prog.push_back(r_word(funct_add, 9, 0, 30));
		prog.push_back(r_word(funct_slt, 10, 0, 30));
		run_program("zero_register");
	endtask

	////////////////////////////////////////
	// main sequence and watchdog
	////////////////////////////////////////

	initial begin
		rst <= 1'b1;
		for (int k = 0; k < rom_depth; k++)
			rom[k] = nop_word;
		reset_and_fetch();
		alu_forwarding();
		store_and_load();
		load_use_stall();
		zero_register();
		$display("tests run %0d, failed %0d, errors %0d", n_tests, tests_failed, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

	initial begin
		#(watchdog_ns);
		$display("timeout, the tests did not finish in %0d ns", watchdog_ns);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

// File: filelist.f
mips_pkg.sv
reg_file.sv
instr_decode.sv
exec_stage.sv
mem_writeback.sv
mips_core.sv
tb_mips_core.sv
